/* files.f */
logic/tc_fmt_pkg.sv
logic/tc_ctrl_pkg.sv
logic/burst_decode.sv
logic/phase_sequencer.sv
logic/axi_request_port.sv
logic/tensor_sched.sv
verif/clk_gen.sv
verif/tensor_sched_checker.sv
verif/tensor_sched_tb.sv

/* logic/axi_request_port.sv */
`timescale 1ns/1ps

module axi_request_port
    import tc_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     issue,
    input  axi_req_t next_req,
    input  logic     arready,
    output axi_req_t req,
    output logic     req_valid
);

    // Fields only change on issue
    always_ff @(posedge clk) begin
        if (issue) begin
            req <= next_req;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            req_valid <= 1'b0;
        end else if (issue) begin
            req_valid <= 1'b1;  // New request beats a same-cycle accept
        end else if (req_valid && arready) begin
            req_valid <= 1'b0;
        end
    end

endmodule

/* logic/burst_decode.sv */
`timescale 1ns/1ps

module burst_decode
    import tc_fmt_pkg::*;
    import tc_ctrl_pkg::*;
#(
    parameter addr_t C_BASE = 32'h0001_0000,
    parameter addr_t A_BASE = 32'h0010_0000,
    parameter addr_t B_BASE = 32'h0100_0000
) (
    input  compute_type_t compute_type,
    input  logic          mixed,
    input  mat_sel_t      next_mat,
    output axi_req_t      next_req,
    output count_t        compute_len
);

    data_type_t dtype;
    shape_t     shape;

    assign dtype = compute_type.data_type;
    assign shape = compute_type.compute_shape;

    assign compute_len = COMPUTE_CYCLES[dtype];

    always_comb begin
        next_req.sel        = next_mat;
        next_req.base       = C_BASE;
        next_req.burst_num  = 6'd31;
        next_req.burst_size = BSZ_32B;
        case (next_mat)
            MAT_C: begin
                next_req.base = C_BASE;  // Always 32 beats
                case (dtype)
                    FP32:    next_req.burst_size = BSZ_32B;
                    FP16:    next_req.burst_size = mixed ? BSZ_32B : BSZ_16B;
                    INT8:    next_req.burst_size = BSZ_8B;
                    default: next_req.burst_size = BSZ_4B;
                endcase
            end
            MAT_A: begin
                next_req.base = A_BASE;
                case (shape)
                    M32K16N8: begin
                        case (dtype)
                            FP32:    next_req.burst_num = 6'd63;
                            FP16:    next_req.burst_num = 6'd31;
                            INT8: begin
                                next_req.burst_num  = 6'd63;
                                next_req.burst_size = BSZ_8B;  // Only narrow A case
                            end
                            default: next_req.burst_num = 6'd7;
                        endcase
                    end
                    M16K16N16: begin
                        case (dtype)
                            FP32:    next_req.burst_num = 6'd31;
                            FP16:    next_req.burst_num = 6'd15;
                            INT8:    next_req.burst_num = 6'd7;
                            default: next_req.burst_num = 6'd3;
                        endcase
                    end
                    default: begin
                        case (dtype)
                            FP32:    next_req.burst_num = 6'd15;
                            FP16:    next_req.burst_num = 6'd7;
                            INT8:    next_req.burst_num = 6'd3;
                            default: next_req.burst_num = 6'd1;
                        endcase
                    end
                endcase
            end
            MAT_B: begin
                next_req.base = B_BASE;
                case (shape)
                    M32K16N8: begin
                        next_req.burst_num = 6'd15;
                        case (dtype)
                            FP32:    next_req.burst_size = BSZ_32B;
                            FP16:    next_req.burst_size = BSZ_16B;
                            INT8:    next_req.burst_size = BSZ_8B;
                            default: next_req.burst_size = BSZ_4B;
                        endcase
                    end
                    M16K16N16: begin
                        case (dtype)
                            FP32:    next_req.burst_num = 6'd31;
                            FP16:    next_req.burst_num = 6'd15;
                            INT8: begin
                                next_req.burst_num  = 6'd15;
                                next_req.burst_size = BSZ_16B;
                            end
                            default: begin
                                next_req.burst_num  = 6'd15;
                                next_req.burst_size = BSZ_8B;
                            end
                        endcase
                    end
                    default: begin
                        case (dtype)
                            FP32:    next_req.burst_num = 6'd63;
                            FP16:    next_req.burst_num = 6'd31;
                            INT8:    next_req.burst_num = 6'd15;
                            default: begin
                                next_req.burst_num  = 6'd15;
                                next_req.burst_size = BSZ_16B;
                            end
                        endcase
                    end
                endcase
            end
            default: next_req.base = C_BASE;
        endcase
    end

endmodule

/* logic/phase_sequencer.sv */
`timescale 1ns/1ps

module phase_sequencer
    import tc_fmt_pkg::*;
    import tc_ctrl_pkg::*;
#(
    parameter int WAIT_CYCLES = 20
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  logic       load_done,
    input  data_type_t data_type,
    input  count_t     compute_len,
    output mat_sel_t   next_mat,
    output logic       issue,
    output logic       compute_en,
    output logic       accumulate_en,
    output logic       writeback_en,
    output logic       done
);

    localparam count_t DRAIN_LOAD = count_t'(WAIT_CYCLES);

    phase_t state;
    count_t cnt;  // Shared by compute and drain

    // Request for the phase being entered
    always_comb begin
        issue    = 1'b0;
        next_mat = MAT_C;
        case (state)
            IDLE:    issue = start;
            READ_C: begin
                next_mat = MAT_A;
                issue    = load_done;
            end
            LOAD_A: begin
                next_mat = MAT_B;
                issue    = load_done;
            end
            default: issue = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                IDLE: if (start) state <= READ_C;
                READ_C: if (load_done) state <= LOAD_A;
                LOAD_A: if (load_done) state <= LOAD_B;
                LOAD_B: begin
                    if (load_done) begin
                        state <= SYSTOLIC;
                        cnt   <= compute_len - 1'b1;
                    end
                end
                SYSTOLIC: begin
                    cnt <= cnt - 1'b1;
                    if (cnt == '0) begin
                        if (data_type == INT4) begin
                            state <= ACCUMULATE;  // Partial sums need folding
                        end else begin
                            state <= WAIT_WRITE;
                            cnt   <= DRAIN_LOAD;
                        end
                    end
                end
                ACCUMULATE: begin
                    state <= WAIT_WRITE;
                    cnt   <= DRAIN_LOAD;
                end
                WAIT_WRITE: begin
                    cnt <= cnt - 1'b1;
                    if (cnt == '0) state <= WRITE_BACK;
                end
                WRITE_BACK: state <= FINISH;
                FINISH:     state <= FINISH;  // Held until reset
                default:    state <= IDLE;
            endcase
        end
    end

    assign compute_en    = (state == SYSTOLIC);
    assign accumulate_en = (state == ACCUMULATE);
    assign writeback_en  = (state == WRITE_BACK);
    assign done          = (state == FINISH);

endmodule

/* logic/tc_ctrl_pkg.sv */
package tc_ctrl_pkg;
    import tc_fmt_pkg::*;

    // One-hot select code on the request channel
    typedef enum logic [2:0] {
        MAT_C = 3'b001,
        MAT_B = 3'b010,
        MAT_A = 3'b100
    } mat_sel_t;

    typedef struct packed {
        mat_sel_t    sel;
        addr_t       base;
        burst_num_t  burst_num;
        burst_size_t burst_size;
    } axi_req_t;

    typedef enum logic [3:0] {
        IDLE,
        READ_C,
        LOAD_A,
        LOAD_B,
        SYSTOLIC,
        ACCUMULATE,
        WAIT_WRITE,
        WRITE_BACK,
        FINISH
    } phase_t;

    typedef logic [6:0] count_t;

    // Compute cycles, indexed by data_type_t
    localparam count_t COMPUTE_CYCLES [4] = '{7'd64, 7'd64, 7'd16, 7'd8};

endpackage

/* logic/tc_fmt_pkg.sv */
package tc_fmt_pkg;

    typedef enum logic [1:0] {
        FP32 = 2'd0,
        FP16 = 2'd1,
        INT8 = 2'd2,
        INT4 = 2'd3
    } data_type_t;

    // Output tile shape, K is fixed at 16
    typedef enum logic [1:0] {
        M32K16N8  = 2'd0,
        M16K16N16 = 2'd1,
        M8K16N32  = 2'd2
    } shape_t;

    typedef struct packed {
        data_type_t data_type;
        shape_t     compute_shape;
    } compute_type_t;

    typedef logic [31:0] addr_t;

    // Beats minus one
    typedef logic [5:0] burst_num_t;

    // log2 of bytes per beat
    typedef logic [2:0] burst_size_t;

    localparam burst_size_t BSZ_4B  = 3'd2;
    localparam burst_size_t BSZ_8B  = 3'd3;
    localparam burst_size_t BSZ_16B = 3'd4;
    localparam burst_size_t BSZ_32B = 3'd5;  // Full 256-bit beat

endpackage

/* logic/tensor_sched.sv */
`timescale 1ns/1ps

module tensor_sched
    import tc_fmt_pkg::*;
    import tc_ctrl_pkg::*;
#(
    parameter addr_t C_BASE      = 32'h0001_0000,
    parameter addr_t A_BASE      = 32'h0010_0000,
    parameter addr_t B_BASE      = 32'h0100_0000,
    parameter int    WAIT_CYCLES = 20
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          start,
    input  logic          mixed,
    input  compute_type_t compute_type,
    input  logic          axi_in_arready,
    input  logic          axi_in_finish,
    output axi_req_t      axi_out_req,
    output logic          axi_out_request_valid,
    output logic          compute_en,
    output logic          accumulate_en,
    output logic          writeback_en,
    output logic          done
);

    mat_sel_t next_mat;
    axi_req_t next_req;
    count_t   compute_len;
    logic     issue;

    burst_decode #(
        .C_BASE (C_BASE),
        .A_BASE (A_BASE),
        .B_BASE (B_BASE)
    ) u_decode (
        .compute_type (compute_type),
        .mixed        (mixed),
        .next_mat     (next_mat),
        .next_req     (next_req),
        .compute_len  (compute_len)
    );

    phase_sequencer #(
        .WAIT_CYCLES (WAIT_CYCLES)
    ) u_seq (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .load_done     (axi_in_finish),
        .data_type     (compute_type.data_type),
        .compute_len   (compute_len),
        .next_mat      (next_mat),
        .issue         (issue),
        .compute_en    (compute_en),
        .accumulate_en (accumulate_en),
        .writeback_en  (writeback_en),
        .done          (done)
    );

    axi_request_port u_req (
        .clk       (clk),
        .rst       (rst),
        .issue     (issue),
        .next_req  (next_req),
        .arready   (axi_in_arready),
        .req       (axi_out_req),
        .req_valid (axi_out_request_valid)
    );

endmodule

/* verif/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen #(
    parameter int HALF_PERIOD = 4,
    parameter int RST_CYCLES  = 5
) (
    output logic clk,
    output logic por
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        por = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1 por = 1'b0;  // Released with the other inputs
    end

endmodule

/* verif/tensor_sched_checker.sv */
`timescale 1ns/1ps

module tensor_sched_checker
    import tc_ctrl_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input axi_req_t axi_out_req,
    input logic     axi_out_request_valid,
    input logic     axi_in_arready,
    input logic     compute_en,
    input logic     accumulate_en,
    input logic     writeback_en,
    input logic     done
);

    int unsigned fail_count = 0;

    valid_held: assert property (@(posedge clk) disable iff (rst)
        axi_out_request_valid && !axi_in_arready |=> axi_out_request_valid)
        else begin
            $error("request valid dropped before arready");
            fail_count++;
        end

    fields_stable: assert property (@(posedge clk) disable iff (rst)
        axi_out_request_valid && !axi_in_arready |=> $stable(axi_out_req))
        else begin
            $error("request fields changed while waiting for arready");
            fail_count++;
        end

    strobes_exclusive: assert property (@(posedge clk) disable iff (rst)
        $onehot0({compute_en, accumulate_en, writeback_en}))
        else begin
            $error("more than one phase strobe high");
            fail_count++;
        end

    done_sticky: assert property (@(posedge clk) disable iff (rst) done |=> done)
        else begin
            $error("done fell without reset");
            fail_count++;
        end

endmodule

bind tensor_sched tensor_sched_checker u_chk (.*);

/* verif/tensor_sched_tb.sv */
`timescale 1ns/1ps

module tensor_sched_tb
    import tc_fmt_pkg::*;
    import tc_ctrl_pkg::*;
;
    localparam addr_t C_BASE = 32'h0001_0000;
    localparam addr_t A_BASE = 32'h0010_0000;
    localparam addr_t B_BASE = 32'h0100_0000;
    localparam int WAIT_CYCLES = 20;
    localparam int NUM_ROWS = 13;
    localparam int ROW_BUDGET = 200;  // Worst case cycles per row

    typedef struct packed {
        shape_t      shape;
        data_type_t  dtype;
        logic        mixed;
        burst_num_t  c_num;
        burst_size_t c_size;
        burst_num_t  a_num;
        burst_size_t a_size;
        burst_num_t  b_num;
        burst_size_t b_size;
        count_t      len;
    } case_row_t;

    logic clk, por, row_rst, rst, start, mixed, axi_in_arready, axi_in_finish;
    logic compute_en, accumulate_en, writeback_en, done, axi_out_request_valid;
    compute_type_t compute_type;
    axi_req_t      axi_out_req;
    case_row_t     rows [NUM_ROWS];

    assign rst = por | row_rst;

    clk_gen u_clk (.clk(clk), .por(por));

    tensor_sched #(.C_BASE(C_BASE), .A_BASE(A_BASE), .B_BASE(B_BASE),
                   .WAIT_CYCLES(WAIT_CYCLES)) uut (.*);

    task automatic load_table();
        rows[0]  = '{M32K16N8,  FP32, 1'b0, 6'd31, 3'd5, 6'd63, 3'd5, 6'd15, 3'd5, 7'd64};
        rows[1]  = '{M32K16N8,  FP16, 1'b0, 6'd31, 3'd4, 6'd31, 3'd5, 6'd15, 3'd4, 7'd64};
        rows[2]  = '{M32K16N8,  INT8, 1'b0, 6'd31, 3'd3, 6'd63, 3'd3, 6'd15, 3'd3, 7'd16};
        rows[3]  = '{M32K16N8,  INT4, 1'b0, 6'd31, 3'd2, 6'd7,  3'd5, 6'd15, 3'd2, 7'd8};
        rows[4]  = '{M16K16N16, FP32, 1'b0, 6'd31, 3'd5, 6'd31, 3'd5, 6'd31, 3'd5, 7'd64};
        rows[5]  = '{M16K16N16, FP16, 1'b0, 6'd31, 3'd4, 6'd15, 3'd5, 6'd15, 3'd5, 7'd64};
        rows[6]  = '{M16K16N16, INT8, 1'b0, 6'd31, 3'd3, 6'd7,  3'd5, 6'd15, 3'd4, 7'd16};
        rows[7]  = '{M16K16N16, INT4, 1'b0, 6'd31, 3'd2, 6'd3,  3'd5, 6'd15, 3'd3, 7'd8};
        rows[8]  = '{M8K16N32,  FP32, 1'b0, 6'd31, 3'd5, 6'd15, 3'd5, 6'd63, 3'd5, 7'd64};
        rows[9]  = '{M8K16N32,  FP16, 1'b0, 6'd31, 3'd4, 6'd7,  3'd5, 6'd31, 3'd5, 7'd64};
        rows[10] = '{M8K16N32,  INT8, 1'b0, 6'd31, 3'd3, 6'd3,  3'd5, 6'd15, 3'd5, 7'd16};
        rows[11] = '{M8K16N32,  INT4, 1'b0, 6'd31, 3'd2, 6'd1,  3'd5, 6'd15, 3'd4, 7'd8};
        rows[12] = '{M16K16N16, FP16, 1'b1, 6'd31, 3'd5, 6'd15, 3'd5, 6'd15, 3'd5, 7'd64};
    endtask

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("error: %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "check failed");
        end
    endtask

    // Outputs are sampled and inputs driven 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic serve_load(input string tag, input mat_sel_t sel, input addr_t base,
                              input burst_num_t num, input burst_size_t size);
        axi_req_t    exp_req;
        int unsigned ready_delay;
        int unsigned finish_delay;
        exp_req      = '{sel: sel, base: base, burst_num: num, burst_size: size};
        ready_delay  = $urandom_range(3, 0);
        finish_delay = $urandom_range(6, 1);
        check_eq({tag, " axi_out_request_valid"}, axi_out_request_valid, 1'b1);
        check_eq({tag, " axi_out_req"}, axi_out_req, exp_req);
        repeat (ready_delay) begin  // Back-pressure
            next_cycle();
            check_eq({tag, " held valid"}, axi_out_request_valid, 1'b1);
            check_eq({tag, " held axi_out_req"}, axi_out_req, exp_req);
        end
        axi_in_arready = 1'b1;
        next_cycle();
        axi_in_arready = 1'b0;
        repeat (finish_delay) begin
            check_eq({tag, " valid after accept"}, axi_out_request_valid, 1'b0);
            next_cycle();
        end
        axi_in_finish = 1'b1;
        next_cycle();
        axi_in_finish = 1'b0;
    endtask

    task automatic run_row(input case_row_t row);
        int n;
        row_rst      = 1'b1;
        compute_type = '{data_type: row.dtype, compute_shape: row.shape};
        mixed        = row.mixed;
        repeat (5) next_cycle();
        row_rst = 1'b0;
        check_eq("outputs after reset", {axi_out_request_valid, compute_en, accumulate_en,
                 writeback_en, done}, 5'b0);
        next_cycle();
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        serve_load("C", MAT_C, C_BASE, row.c_num, row.c_size);
        serve_load("A", MAT_A, A_BASE, row.a_num, row.a_size);
        serve_load("B", MAT_B, B_BASE, row.b_num, row.b_size);
        check_eq("compute_en after B finish", compute_en, 1'b1);
        n = 0;
        while (compute_en === 1'b1) begin
            n++;
            next_cycle();
        end
        check_eq("compute_en cycles", n, row.len);
        if (row.dtype == INT4) begin
            check_eq("accumulate_en", accumulate_en, 1'b1);
            next_cycle();
        end
        n = 0;
        while (writeback_en !== 1'b1) begin
            check_eq("strobes in drain", {compute_en, accumulate_en, done}, 3'b0);
            n++;
            next_cycle();
        end
        check_eq("drain cycles", n, WAIT_CYCLES + 1);
        next_cycle();
        check_eq("writeback_en", writeback_en, 1'b0);
        axi_in_finish = 1'b1;  // Stray finish, must be ignored
        repeat (4) begin
            check_eq("done", done, 1'b1);
            check_eq("axi_out_request_valid when done", axi_out_request_valid, 1'b0);
            next_cycle();
            axi_in_finish = 1'b0;
        end
    endtask

    initial begin
        #(NUM_ROWS * ROW_BUDGET * 8);
        $display("timeout: the scheduler did not complete all table rows in time");
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

    // Bound assertions count their failures
    initial begin
        wait (uut.u_chk.fail_count != 0);
        $display("error: a bound protocol assertion failed at %0t", $time);
        $display("=== FAIL ===");
        $fatal(1, "assertion failed");
    end

    initial begin
        void'($urandom(32'h5bea));
        row_rst        = 1'b1;
        start          = 1'b0;
        mixed          = 1'b0;
        compute_type   = '0;
        axi_in_arready = 1'b0;
        axi_in_finish  = 1'b0;
        load_table();
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(rows[i]);
        end
        if (uut.u_chk.fail_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("=== FAIL ===");
            $fatal(1, "assertion failed");
        end
    end

endmodule
